//--- logic/dpTypesPkg.sv
// Data types shared by the datapath blocks and the testbench: the bus word, Z content, ALU opcodes
`default_nettype none

package dpTypesPkg;

  localparam int dpWordBits = 32; // width of the shared bus

  // one bus word, also the width of every register
  typedef logic [dpWordBits-1:0] dpWord_t;

  // Z register content, high word on top
  typedef struct packed {
    dpWord_t hi; // upper half, carries or shifted-out bits
    dpWord_t lo; // lower half, the usual result
  } dpWide_t;

  // ALU opcodes, numbered like the instruction opcode field
  typedef enum logic [4:0] {
    opAnd = 5'd1,
    opOr  = 5'd2,
    opAdd = 5'd3,
    opSub = 5'd4,
    opShl = 5'd5, // Y shifted left by bus[4:0]
    opShr = 5'd6, // logical shift right
    opNeg = 5'd7, // unary, works on the bus only
    opNot = 5'd8  // unary as well
  } aluOp_t;

endpackage : dpTypesPkg

`default_nettype wire

//--- logic/dpCtrlPkg.sv
// Control strobe bundles for the datapath, driven cycle by cycle by the sequencer or testbench
`default_nettype none

package dpCtrlPkg;

  // Bus output strobes of the fixed sources.
  // The general registers have their own one-hot vector, sized by numRegs.
  // Together with that vector at most one bit may be high per cycle.
  typedef struct packed {
    logic pcOut;  // PC onto the bus
    logic mdrOut; // MDR onto the bus
    logic zHiOut; // upper Z word onto the bus
    logic zLoOut; // lower Z word onto the bus
  } srcStrobes_t;

  // Load strobes, each sampled at the rising edge that ends its cycle.
  // memRead is a level that steers the MDR input, incPc steers the Z input.
  typedef struct packed {
    logic pcIn;    // PC takes the bus
    logic marIn;   // MAR takes the bus
    logic mdrIn;   // MDR takes memory or bus
    logic irIn;    // IR takes the bus
    logic yIn;     // Y takes the bus
    logic zIn;     // Z takes the ALU result
    logic memRead; // MDR source is memory data
    logic incPc;   // ALU forms bus + 1
  } loadStrobes_t;

endpackage : dpCtrlPkg

`default_nettype wire

//--- logic/busSource.sv
// Bus source block: PC, MAR, MDR and IR registers and the encoder that drives the shared bus
`default_nettype none
`timescale 1ns/100ps

module busSource (
  input  logic                   Clock,
  input  logic                   rstN,
  input  dpCtrlPkg::srcStrobes_t srcSel,
  input  dpCtrlPkg::loadStrobes_t loadSel,
  input  dpTypesPkg::dpWord_t    memDataIn,
  input  dpTypesPkg::dpWord_t    regReadWord,
  input  dpTypesPkg::dpWord_t    zHi,
  input  dpTypesPkg::dpWord_t    zLo,
  input  logic                   regOutEn,
  output dpTypesPkg::dpWord_t    busValue,
  output dpTypesPkg::dpWord_t    memAddr,
  output dpTypesPkg::dpWord_t    irValue
);

  import dpTypesPkg::*;

  dpWord_t pcReg;
  dpWord_t marReg;
  dpWord_t mdrReg;
  dpWord_t irReg;
  dpWord_t mdrNext;

  // MDR input mux, memory wins while memRead is up
  assign mdrNext = loadSel.memRead ? memDataIn : busValue;

  always_ff @(posedge Clock) begin
    if (!rstN) begin
      pcReg  <= '0;
      marReg <= '0;
      mdrReg <= '0;
      irReg  <= '0;
    end else begin
      if (loadSel.pcIn) begin
        pcReg <= busValue;
      end
      if (loadSel.marIn) begin
        marReg <= busValue;
      end
      if (loadSel.mdrIn) begin
        mdrReg <= mdrNext;
      end
      if (loadSel.irIn) begin
        irReg <= busValue;
      end
    end
  end

  // Bus encoder. Strobes are one-hot, so an AND-OR tree is enough and
  // an idle bus falls out as 0 without a separate default term.
  always_comb begin
    busValue = '0;
    busValue = busValue | ({$bits(dpWord_t){srcSel.pcOut}} & pcReg);
    busValue = busValue | ({$bits(dpWord_t){srcSel.mdrOut}} & mdrReg);
    busValue = busValue | ({$bits(dpWord_t){srcSel.zHiOut}} & zHi);
    busValue = busValue | ({$bits(dpWord_t){srcSel.zLoOut}} & zLo);
    busValue = busValue | ({$bits(dpWord_t){regOutEn}} & regReadWord); // word is 0 if no reg
  end

  assign memAddr = marReg; // MAR drives the memory address lines
  assign irValue = irReg;  // decoder would sit here

endmodule : busSource

`default_nettype wire

//--- logic/regFile.sv
// General-purpose register file: loads from the bus on one-hot strobes and reads one word back
`default_nettype none
`timescale 1ns/100ps

module regFile #(
  parameter int numRegs = 16
) (
  input  logic                Clock,
  input  logic                rstN,
  input  logic [numRegs-1:0]  regInSel,
  input  logic [numRegs-1:0]  regOutSel,
  input  dpTypesPkg::dpWord_t busValue,
  output dpTypesPkg::dpWord_t regReadWord,
  output logic                regOutEn
);

  import dpTypesPkg::*;

  dpWord_t regs [numRegs];

  // several input strobes may be high together, each register captures
  always_ff @(posedge Clock) begin
    if (!rstN) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int i = 0; i < numRegs; i++) begin
        if (regInSel[i]) begin
          regs[i] <= busValue;
        end
      end
    end
  end

  // one-hot read-out, gives 0 when nothing is selected
  always_comb begin
    regReadWord = '0;
    for (int i = 0; i < numRegs; i++) begin
      regReadWord = regReadWord | ({$bits(dpWord_t){regOutSel[i]}} & regs[i]);
    end
  end

  assign regOutEn = |regOutSel; // tells the encoder a register owns the bus

endmodule : regFile

`default_nettype wire

//--- logic/aluUnit.sv
// ALU block: Y operand register, the ALU itself and the 64-bit Z result register
`default_nettype none
`timescale 1ns/100ps

module aluUnit (
  input  logic                    Clock,
  input  logic                    rstN,
  input  dpCtrlPkg::loadStrobes_t loadSel,
  input  dpTypesPkg::aluOp_t      aluOp,
  input  dpTypesPkg::dpWord_t     busValue,
  output dpTypesPkg::dpWord_t     zHi,
  output dpTypesPkg::dpWord_t     zLo
);

  import dpTypesPkg::*;

  dpWord_t   yReg;
  dpWide_t   zReg;
  dpWide_t   aluResult;
  logic [4:0] shiftAmt;

  assign shiftAmt = busValue[4:0]; // only the low bits count

  always_ff @(posedge Clock) begin
    if (!rstN) begin
      yReg <= '0;
    end else if (loadSel.yIn) begin
      yReg <= busValue;
    end
  end

  // Y is the first operand, the bus the second
  always_comb begin
    aluResult = '0;
    if (loadSel.incPc) begin
      aluResult.lo = busValue + 32'd1; // PC increment, opcode ignored
    end else begin
      case (aluOp)
        opAnd: aluResult.lo = yReg & busValue;
        opOr:  aluResult.lo = yReg | busValue;
        opAdd: aluResult = {32'd0, yReg} + {32'd0, busValue}; // carry ends up in hi
        opSub: begin
          // sign-extended so hi holds the borrow as all ones
          aluResult = {{32{yReg[31]}}, yReg} - {{32{busValue[31]}}, busValue};
        end
        opShl: aluResult = {32'd0, yReg} << shiftAmt; // bits shifted out land in hi
        opShr: aluResult.lo = yReg >> shiftAmt;
        opNeg: aluResult.lo = ~busValue + 32'd1;
        opNot: aluResult.lo = ~busValue;
        default: aluResult = '0;
      endcase
    end
  end

  always_ff @(posedge Clock) begin
    if (!rstN) begin
      zReg <= '0;
    end else if (loadSel.zIn) begin
      zReg <= aluResult;
    end
  end

  assign zHi = zReg.hi;
  assign zLo = zReg.lo; // read back with zLoOut

endmodule : aluUnit

`default_nettype wire

//--- logic/dataPath.sv
// Datapath top level: wires the bus source block, register file and ALU around the shared bus
`default_nettype none
`timescale 1ns/100ps

module dataPath #(
  parameter int numRegs = 16
) (
  input  logic                    Clock,
  input  logic                    rstN,
  input  dpCtrlPkg::srcStrobes_t  srcSel,
  input  dpCtrlPkg::loadStrobes_t loadSel,
  input  logic [numRegs-1:0]      regOutSel,
  input  logic [numRegs-1:0]      regInSel,
  input  dpTypesPkg::aluOp_t      aluOp,
  input  dpTypesPkg::dpWord_t     memDataIn,
  output dpTypesPkg::dpWord_t     busValue,
  output dpTypesPkg::dpWord_t     memAddr,
  output dpTypesPkg::dpWord_t     irValue
);

  import dpTypesPkg::*;

  dpWord_t regReadWord;
  logic    regOutEn;
  dpWord_t zHi;
  dpWord_t zLo;

  busSource u_busSource (
    .Clock       (Clock),
    .rstN        (rstN),
    .srcSel      (srcSel),
    .loadSel     (loadSel),
    .memDataIn   (memDataIn),
    .regReadWord (regReadWord),
    .zHi         (zHi),
    .zLo         (zLo),
    .regOutEn    (regOutEn),
    .busValue    (busValue),
    .memAddr     (memAddr),
    .irValue     (irValue)
  );

  regFile #(
    .numRegs (numRegs)
  ) u_regFile (
    .Clock       (Clock),
    .rstN        (rstN),
    .regInSel    (regInSel),
    .regOutSel   (regOutSel),
    .busValue    (busValue),
    .regReadWord (regReadWord),
    .regOutEn    (regOutEn)
  );

  aluUnit u_aluUnit (
    .Clock    (Clock),
    .rstN     (rstN),
    .loadSel  (loadSel),
    .aluOp    (aluOp),
    .busValue (busValue),
    .zHi      (zHi),
    .zLo      (zLo)
  );

endmodule : dataPath

`default_nettype wire

//--- dv/tbClockGen.sv
// Testbench clock and reset source: free-running clock, active-low reset held for a few cycles
`default_nettype none
`timescale 1ns/100ps

module tbClockGen #(
  parameter int resetCycles = 5
) (
  output logic Clock,
  output logic rstN
);

  initial begin
    Clock = 1'b0;
    forever #2 Clock = ~Clock; // 4 ns period
  end

  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge Clock);
    #1 rstN = 1'b1; // released in the drive slot after the edge
  end

endmodule : tbClockGen

`default_nettype wire

//--- dv/dataPath_chk.sv
// Assertions bound to the datapath top level that watch bus strobe legality, idle bus and reset state
`default_nettype none
`timescale 1ns/100ps

module dataPath_chk #(
  parameter int numRegs = 16
) (
  input logic                   Clock,
  input logic                   rstN,
  input dpCtrlPkg::srcStrobes_t srcSel,
  input logic [numRegs-1:0]     regOutSel,
  input dpTypesPkg::dpWord_t    busValue,
  input dpTypesPkg::dpWord_t    memAddr,
  input dpTypesPkg::dpWord_t    irValue
);

  logic [numRegs+3:0] outStrobes;

  assign outStrobes = {srcSel, regOutSel}; // every bus driver in one vector

  strobeOneHot: assert property (@(posedge Clock) disable iff (!rstN) $onehot0(outStrobes))
    else $error("more than one bus output strobe is high");

  idleBusZero: assert property (@(posedge Clock) disable iff (!rstN)
    (outStrobes == '0) |-> (busValue == '0))
    else $error("bus is not 0 while no output strobe is high");

  resetState: assert property (@(posedge Clock)
    $rose(rstN) |-> (memAddr == '0 && irValue == '0))
    else $error("MAR or IR is not 0 after reset");

endmodule : dataPath_chk

bind dataPath dataPath_chk #(.numRegs(numRegs)) u_chk (
  .Clock     (Clock),
  .rstN      (rstN),
  .srcSel    (srcSel),
  .regOutSel (regOutSel),
  .busValue  (busValue),
  .memAddr   (memAddr),
  .irValue   (irValue)
);

`default_nettype wire

//--- dv/dataPathTb.sv
// Directed testbench that drives strobe sequences into the datapath and checks them against a model
`default_nettype none
`timescale 1ns/100ps

module dataPathTb;

  import dpTypesPkg::*;
  import dpCtrlPkg::*;

  localparam int numRegs = 16;
  localparam int resetTimeout = 50; // cycles
  localparam int runLimitNs = 20000;

  logic               Clock;
  logic               rstN;
  srcStrobes_t        srcSel;
  loadStrobes_t       loadSel;
  logic [numRegs-1:0] regOutSel;
  logic [numRegs-1:0] regInSel;
  aluOp_t             aluOp;
  dpWord_t            memDataIn;
  dpWord_t            busValue;
  dpWord_t            memAddr;
  dpWord_t            irValue;

  dpWord_t regModel [numRegs]; // expected general register contents
  int      errCount;
  int      checkCount;

  tbClockGen #(.resetCycles(5)) u_clockGen (.Clock(Clock), .rstN(rstN));

  dataPath #(.numRegs(numRegs)) u_dut (
    .Clock     (Clock),
    .rstN      (rstN),
    .srcSel    (srcSel),
    .loadSel   (loadSel),
    .regOutSel (regOutSel),
    .regInSel  (regInSel),
    .aluOp     (aluOp),
    .memDataIn (memDataIn),
    .busValue  (busValue),
    .memAddr   (memAddr),
    .irValue   (irValue)
  );

  task automatic clearInputs();
    srcSel = '0;
    loadSel = '0;
    regOutSel = '0;
    regInSel = '0;
    aluOp = opAnd;
    memDataIn = '0;
  endtask

  // ends the current cycle and returns to the drive slot 1 ns after the edge
  task automatic finishCycle();
    @(posedge Clock);
    #1;
    clearInputs();
  endtask

  task automatic checkWord(input string what, input dpWord_t got, input dpWord_t expected);
    checkCount++;
    if (got !== expected) begin
      errCount++;
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, expected);
    end
  endtask

  task automatic checkOp(input aluOp_t op, input dpWord_t got, input dpWord_t expected);
    checkCount++;
    if (got !== expected) begin
      errCount++;
      $display("MISMATCH at %0t: %s result is %h, expected %h", $time, op.name(), got, expected);
    end
  endtask

  // a is the first operand (held in Y), b the second (on the bus)
  function automatic dpWord_t expectedAlu(aluOp_t op, dpWord_t a, dpWord_t b);
    case (op)
      opAnd:   return a & b;
      opOr:    return a | b;
      opAdd:   return a + b;
      opSub:   return a - b;
      opShl:   return a << b[4:0];
      opShr:   return a >> b[4:0];
      opNeg:   return 32'd0 - b;
      opNot:   return ~b;
      default: return '0;
    endcase
  endfunction

  task automatic waitForReset();
    int cycles;
    cycles = 0;
    while (rstN !== 1'b1 && cycles < resetTimeout) begin
      @(posedge Clock);
      cycles++;
    end
    if (rstN !== 1'b1) begin
      errCount++;
      $display("reset was never released within %0d cycles", resetTimeout);
    end
    #1;
  endtask

  task automatic readReg(input int idx, output dpWord_t value);
    regOutSel[idx] = 1'b1;
    #1 value = busValue;
    finishCycle();
  endtask

  // loads MDR from memory and moves it over the bus into the register
  task automatic loadFromMemory(input int idx, input dpWord_t word);
    memDataIn = word;
    loadSel.memRead = 1'b1;
    loadSel.mdrIn = 1'b1;
    finishCycle();
    srcSel.mdrOut = 1'b1;
    regInSel[idx] = 1'b1;
    finishCycle();
    regModel[idx] = word;
  endtask

  task automatic testResetState();
    dpWord_t value;
    for (int k = 0; k < 4; k++) begin
      srcSel[k] = 1'b1; // one fixed source at a time
      #1 checkWord($sformatf("bus with source %0d after reset", k), busValue, '0);
      finishCycle();
    end
    for (int i = 0; i < numRegs; i++) begin
      readReg(i, value);
      checkWord($sformatf("R%0d after reset", i), value, '0);
    end
    #1 checkWord("idle bus", busValue, '0);
    checkWord("memAddr after reset", memAddr, '0);
    checkWord("irValue after reset", irValue, '0);
    finishCycle();
  endtask

  task automatic testMemoryLoad();
    dpWord_t value;
    for (int i = 0; i < numRegs; i++) begin
      loadFromMemory(i, $urandom());
      readReg(i, value);
      checkWord($sformatf("R%0d after memory load", i), value, regModel[i]);
    end
  endtask

  task automatic testAluOps();
    aluOp_t  op;
    dpWord_t a, b, result, expected;
    op = op.first();
    do begin
      a = $urandom();
      b = $urandom();
      loadFromMemory(1, a);
      loadFromMemory(2, b);
      regOutSel[1] = 1'b1;
      loadSel.yIn = 1'b1;
      finishCycle();
      regOutSel[2] = 1'b1;
      loadSel.zIn = 1'b1;
      aluOp = op;
      finishCycle();
      srcSel.zLoOut = 1'b1;
      regInSel[3] = 1'b1;
      finishCycle();
      expected = expectedAlu(op, a, b);
      regModel[3] = expected;
      readReg(3, result);
      checkOp(op, result, expected);
      op = op.next();
    end while (op != op.first());
  endtask

  task automatic testFetch();
    dpWord_t pcOld, instr;
    pcOld = $urandom();
    instr = $urandom();
    memDataIn = pcOld; // PC preset through MDR
    loadSel.memRead = 1'b1;
    loadSel.mdrIn = 1'b1;
    finishCycle();
    srcSel.mdrOut = 1'b1;
    loadSel.pcIn = 1'b1;
    finishCycle();
    srcSel.pcOut = 1'b1;
    loadSel.marIn = 1'b1;
    loadSel.zIn = 1'b1;
    loadSel.incPc = 1'b1;
    aluOp = opNot; // increment must win over the opcode
    finishCycle();
    srcSel.zLoOut = 1'b1;
    loadSel.pcIn = 1'b1;
    loadSel.memRead = 1'b1;
    loadSel.mdrIn = 1'b1;
    memDataIn = instr;
    finishCycle();
    srcSel.mdrOut = 1'b1;
    loadSel.irIn = 1'b1;
    finishCycle();
    checkWord("memAddr after fetch", memAddr, pcOld);
    checkWord("irValue after fetch", irValue, instr);
    srcSel.pcOut = 1'b1;
    #1 checkWord("PC after fetch", busValue, pcOld + 32'd1);
    finishCycle();
    srcSel.zHiOut = 1'b1; // Z still holds the increment result
    #1 checkWord("Z high after increment", busValue, '0);
    finishCycle();
  endtask

  task automatic testIsolation();
    int      idx;
    dpWord_t value;
    idx = $urandom % numRegs;
    loadFromMemory(idx, $urandom());
    for (int i = 0; i < numRegs; i++) begin
      readReg(i, value);
      checkWord($sformatf("R%0d after write to R%0d", i, idx), value, regModel[i]);
    end
  endtask

  initial begin
    errCount = 0;
    checkCount = 0;
    clearInputs();
    for (int i = 0; i < numRegs; i++) begin
      regModel[i] = '0;
    end
    void'($urandom(32'h75e1_eec1));
    waitForReset();
    testResetState();
    testMemoryLoad();
    testAluOps();
    testFetch();
    testIsolation();
    $display("checks: %0d, errors: %0d", checkCount, errCount);
    if (errCount == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #(runLimitNs);
    $display("timeout: the run did not finish within %0d ns", runLimitNs);
    $display("=== FAIL ===");
    $finish;
  end

endmodule : dataPathTb

`default_nettype wire

//--- project.f
logic/dpTypesPkg.sv
logic/dpCtrlPkg.sv
logic/busSource.sv
logic/regFile.sv
logic/aluUnit.sv
logic/dataPath.sv
dv/tbClockGen.sv
dv/dataPath_chk.sv
dv/dataPathTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -f project.f --top-module dataPathTb \
  -o dataPathSim > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/dataPathSim > sim.log 2>&1
grep -q "^=== PASS ===$" sim.log && echo "simulation passed" || { echo "simulation failed, see sim.log"; exit 1; }
